/* sim.f */
+incdir+src
src/csi_raw_pkg.sv
src/raw_format_decode.sv
src/raw_byte_unpacker.sv
src/pixel_output_stage.sv
src/csi_raw_depacker.sv
verif/csi_raw_depacker_checker.sv
verif/tb_csi_raw_depacker.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csi_raw_depacker
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) src/csi_raw_consts.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_csi_raw_depacker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_raw_consts.svh"

module tb_csi_raw_depacker;
        import csi_raw_pkg::*;

        localparam int PIXEL_WIDTH    = 16;
        localparam int BEAT_BITS      = `CSI_PIXELS_PER_BEAT * PIXEL_WIDTH;
        localparam int RESET_CYCLES   = 8;
        localparam int DRAIN_CYCLES   = 6;
        localparam int LINE_WORDS     = 10 + 12 + 8 + 3 + 13 + 11 + 13;  // all lines below
        localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 + LINE_WORDS + 1
                                        + 6 * DRAIN_CYCLES + 40;

        logic                      clk_i;
        logic                      reset_i;
        logic                      data_valid_i;
        logic [`CSI_WORD_BITS-1:0] data_i;
        logic [2:0]                packet_type_i;
        logic                      output_valid_o;
        logic [BEAT_BITS-1:0]      output_o;
        logic                      raw_line_o;

        integer               seed = 32'hf723;
        int                   cycle_count = 0;
        int                   error_count = 0;
        int                   beat_count = 0;
        logic                 last_valid = 1'b0;        // what the DUT took at the last edge
        logic                 last_supported = 1'b0;
        logic [BEAT_BITS-1:0] exp_beat_q[$];
        int                   exp_due_q[$];
        logic [7:0]           line_bytes[$];
        logic [BEAT_BITS-1:0] line_beats[$];

        csi_raw_depacker #(
                .PIXEL_WIDTH    (PIXEL_WIDTH)
        ) i_dut (
                .clk_i          (clk_i),
                .reset_i        (reset_i),
                .data_valid_i   (data_valid_i),
                .data_i         (data_i),
                .packet_type_i  (packet_type_i),
                .output_valid_o (output_valid_o),
                .output_o       (output_o),
                .raw_line_o     (raw_line_o)
        );

        bind csi_raw_depacker csi_raw_depacker_checker #(
                .PIXEL_WIDTH    (PIXEL_WIDTH)
        ) i_checker (
                .clk_i          (clk_i),
                .reset_i        (reset_i),
                .output_valid_i (output_valid_o),
                .output_i       (output_o),
                .raw_line_i     (raw_line_o),
                .line_format_i  (line_format)
        );

        initial
        begin
                clk_i = 1'b0;
                forever
                begin
                        #4 clk_i = ~clk_i;
                end
        end

        always @(posedge clk_i)
        begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES)
                begin
                        $display("timeout: the run did not finish within %0d cycles",
                                 TIMEOUT_CYCLES);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        task automatic record_failure(input string msg);
                $display("FAILED at %0d ns: %s", $time, msg);
                error_count++;
        endtask

        // registered outputs are stable at the falling edge
        task automatic check_outputs;
                logic                 exp_valid;
                logic                 exp_line;
                logic [BEAT_BITS-1:0] exp_beat;
                exp_valid = (exp_due_q.size() > 0) && (exp_due_q[0] == cycle_count);
                exp_line  = (last_valid && last_supported) || exp_valid;
                assert (output_valid_o === exp_valid)
                else record_failure($sformatf("output_valid_o %b, expected %b",
                                              output_valid_o, exp_valid));
                assert (raw_line_o === exp_line)
                else record_failure($sformatf("raw_line_o %b, expected %b",
                                              raw_line_o, exp_line));
                if (exp_valid)
                begin
                        exp_beat = exp_beat_q.pop_front();
                        void'(exp_due_q.pop_front());
                        beat_count++;
                        assert (output_o === exp_beat)
                        else record_failure($sformatf("beat %h, expected %h", output_o, exp_beat));
                end
        endtask

        task automatic step_cycle(input logic valid, input logic [`CSI_WORD_BITS-1:0] word,
                                  input logic [2:0] code);
                @(negedge clk_i);
                check_outputs();
                data_valid_i   = valid;
                data_i         = word;
                packet_type_i  = code;
                last_valid     = valid;
                last_supported = (code == PKT_RAW10) || (code == PKT_RAW12);
        endtask

        task automatic idle_cycles(input int cycles);
                repeat (cycles) step_cycle(1'b0, '0, 3'd0);
        endtask

        // eight random pixels packed into one group of line bytes
        task automatic make_group(input logic [2:0] code);
                logic [11:0]          pix [8];
                logic [BEAT_BITS-1:0] beat;
                int                   bits;
                bits = (code == PKT_RAW12) ? 12 : 10;
                for (int p = 0; p < 8; p++)
                begin
                        pix[p] = 12'($random(seed)) & ((12'd1 << bits) - 12'd1);
                        beat[p*PIXEL_WIDTH +: PIXEL_WIDTH] =
                                PIXEL_WIDTH'(pix[p]) << (PIXEL_WIDTH - bits);
                end
                for (int u = 0; u < 4 && code == PKT_RAW12; u++)
                begin
                        line_bytes.push_back(pix[2*u][11:4]);
                        line_bytes.push_back(pix[2*u+1][11:4]);
                        line_bytes.push_back({pix[2*u+1][3:0], pix[2*u][3:0]});
                end
                for (int u = 0; u < 2 && code != PKT_RAW12; u++)
                begin
                        for (int k = 0; k < 4; k++)
                        begin
                                line_bytes.push_back(pix[4*u+k][9:2]);
                        end
                        line_bytes.push_back({pix[4*u+3][1:0], pix[4*u+2][1:0],
                                              pix[4*u+1][1:0], pix[4*u][1:0]});
                end
                line_beats.push_back(beat);
        endtask

        task automatic send_line(input logic [2:0] code, input int words);
                int                        group_bytes;
                int                        group;
                logic [`CSI_WORD_BITS-1:0] word;
                line_bytes.delete();
                line_beats.delete();
                group_bytes = (code == PKT_RAW12) ? `CSI_GROUP_BYTES_RAW12
                                                  : `CSI_GROUP_BYTES_RAW10;
                group = 0;
                while (line_bytes.size() < 4 * words)
                begin
                        make_group(code);
                end
                for (int w = 0; w < words; w++)
                begin
                        word = {line_bytes[4*w+3], line_bytes[4*w+2],
                                line_bytes[4*w+1], line_bytes[4*w]};
                        step_cycle(1'b1, word, code);
                        // the word carrying a group's last byte sets when its beat is due
                        if (last_supported && (group + 1) * group_bytes <= 4 * (w + 1))
                        begin
                                exp_beat_q.push_back(line_beats[group]);
                                exp_due_q.push_back(cycle_count + 2);
                                group++;
                        end
                end
        endtask

        initial
        begin
                reset_i       = 1'b1;
                data_valid_i  = 1'b0;
                data_i        = '0;
                packet_type_i = 3'd0;
                repeat (RESET_CYCLES) @(posedge clk_i);
                @(negedge clk_i);
                reset_i = 1'b0;

                idle_cycles(20);                        // nothing may come out with no input
                send_line(PKT_RAW10, 10);
                idle_cycles(DRAIN_CYCLES);
                send_line(PKT_RAW12, 12);
                idle_cycles(DRAIN_CYCLES);
                send_line(PKT_RAW14, 8);                // unsupported type gives no pixels
                idle_cycles(DRAIN_CYCLES);
                send_line(PKT_RAW10, 3);                // one beat and two stray bytes
                idle_cycles(DRAIN_CYCLES);
                send_line(PKT_RAW12, 13);
                idle_cycles(DRAIN_CYCLES);
                send_line(PKT_RAW10, 11);               // back-to-back lines with one idle cycle
                idle_cycles(1);
                send_line(PKT_RAW12, 13);
                idle_cycles(DRAIN_CYCLES);

                assert (exp_beat_q.size() == 0)
                else
                begin
                        $display("%0d expected beats never came out of the DUT", exp_beat_q.size());
                        error_count++;
                end

                $display("beats checked: %0d, errors: %0d, checker assertion failures: %0d",
                         beat_count, error_count, i_dut.i_checker.fail_count);
                if (error_count == 0 && i_dut.i_checker.fail_count == 0)
                begin
                        $display("TEST PASSED");
                end
                else
                begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* verif/csi_raw_depacker_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_raw_consts.svh"

module csi_raw_depacker_checker #(
        parameter int PIXEL_WIDTH = 16
) (
        input  logic                                          clk_i,
        input  logic                                          reset_i,
        input  logic                                          output_valid_i,
        input  logic [`CSI_PIXELS_PER_BEAT*PIXEL_WIDTH-1:0]   output_i,
        input  logic                                          raw_line_i,
        input  csi_raw_pkg::raw_format_e                      line_format_i
);
        import csi_raw_pkg::*;

        raw_format_e beat_format_q;                     // format of the group behind the beat
        logic        pad_clear;
        int unsigned fail_count = 0;

        always_ff @(posedge clk_i)
        begin
                beat_format_q <= line_format_i;
        end

        // raw10 leaves six zero bits per slot, raw12 leaves four
        always_comb
        begin
                pad_clear = 1'b1;
                for (int p = 0; p < `CSI_PIXELS_PER_BEAT; p++)
                begin
                        for (int b = 0; b < PIXEL_WIDTH - 10; b++)
                        begin
                                if (output_i[p*PIXEL_WIDTH + b] &&
                                    (beat_format_q == FMT_RAW10 || b < PIXEL_WIDTH - 12))
                                begin
                                        pad_clear = 1'b0;
                                end
                        end
                end
        end

        valid_in_line_a: assert property (@(posedge clk_i) disable iff (reset_i)
                output_valid_i |-> raw_line_i)
        else
        begin
                $error("beat outside an active raw line");
                fail_count++;
        end

        padding_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
                output_valid_i |-> pad_clear)
        else
        begin
                $error("nonzero padding bits in an output slot");
                fail_count++;
        end

        supported_only_a: assert property (@(posedge clk_i) disable iff (reset_i)
                output_valid_i |-> (beat_format_q != FMT_NONE))
        else
        begin
                $error("beat produced for an unsupported packet type");
                fail_count++;
        end

endmodule

`default_nettype wire

/* src/csi_raw_depacker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_raw_consts.svh"

module csi_raw_depacker #(
        parameter int PIXEL_WIDTH = 16
) (
        input  logic                                          clk_i,
        input  logic                                          reset_i,
        input  logic                                          data_valid_i,
        input  logic [`CSI_WORD_BITS-1:0]                     data_i,
        input  logic [2:0]                                    packet_type_i,
        output logic                                          output_valid_o,
        output logic [`CSI_PIXELS_PER_BEAT*PIXEL_WIDTH-1:0]   output_o,
        output logic                                          raw_line_o
);
        import csi_raw_pkg::*;

        raw_format_e                                   line_format;
        logic                                          line_active;
        logic                                          group_ready;
        logic [`CSI_PIXELS_PER_BEAT*PIXEL_WIDTH-1:0]   group_pixels;

        raw_format_decode i_decode (
                .clk_i          (clk_i),
                .reset_i        (reset_i),
                .data_valid_i   (data_valid_i),
                .packet_type_i  (csi_packet_type_e'(packet_type_i)),    // raw code from the packet header
                .line_format_o  (line_format),
                .line_active_o  (line_active)
        );

        raw_byte_unpacker #(
                .PIXEL_WIDTH    (PIXEL_WIDTH)
        ) i_unpacker (
                .clk_i          (clk_i),
                .reset_i        (reset_i),
                .data_valid_i   (data_valid_i),
                .data_i         (data_i),
                .line_format_i  (line_format),
                .line_active_i  (line_active),
                .group_ready_o  (group_ready),
                .group_pixels_o (group_pixels)
        );

        pixel_output_stage #(
                .PIXEL_WIDTH    (PIXEL_WIDTH)
        ) i_output (
                .clk_i          (clk_i),
                .reset_i        (reset_i),
                .group_ready_i  (group_ready),
                .group_pixels_i (group_pixels),
                .line_active_i  (line_active),
                .line_format_i  (line_format),
                .output_valid_o (output_valid_o),
                .output_o       (output_o),
                .raw_line_o     (raw_line_o)
        );

endmodule

`default_nettype wire

/* src/pixel_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_raw_consts.svh"

module pixel_output_stage #(
        parameter int PIXEL_WIDTH = 16
) (
        input  logic                                          clk_i,
        input  logic                                          reset_i,
        input  logic                                          group_ready_i,
        input  logic [`CSI_PIXELS_PER_BEAT*PIXEL_WIDTH-1:0]   group_pixels_i,
        input  logic                                          line_active_i,
        input  csi_raw_pkg::raw_format_e                      line_format_i,
        output logic                                          output_valid_o,
        output logic [`CSI_PIXELS_PER_BEAT*PIXEL_WIDTH-1:0]   output_o,
        output logic                                          raw_line_o
);
        import csi_raw_pkg::*;

        logic line_supported;

        always_ff @(posedge clk_i)
        begin
                if (reset_i)
                begin
                        output_valid_o <= 1'b0;
                end
                else
                begin
                        output_valid_o <= group_ready_i;        // one pulse per ready group
                end
        end

        always_ff @(posedge clk_i)
        begin
                if (group_ready_i)
                begin
                        output_o <= group_pixels_i;     // beat holds until the next group
                end
        end

        assign line_supported = line_active_i && (line_format_i != FMT_NONE);

        // the unpacker flushes once line_active_i drops, so the beat in flight
        // at that point is the last one of the line
        assign raw_line_o = line_supported || output_valid_o;

endmodule

`default_nettype wire

/* src/raw_byte_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csi_raw_consts.svh"

module raw_byte_unpacker #(
        parameter int PIXEL_WIDTH = 16
) (
        input  logic                                          clk_i,
        input  logic                                          reset_i,
        input  logic                                          data_valid_i,
        input  logic [`CSI_WORD_BITS-1:0]                     data_i,
        input  csi_raw_pkg::raw_format_e                      line_format_i,
        input  logic                                          line_active_i,
        output logic                                          group_ready_o,
        output logic [`CSI_PIXELS_PER_BEAT*PIXEL_WIDTH-1:0]   group_pixels_o
);
        import csi_raw_pkg::*;

        localparam int BUF_BYTES = `CSI_BUFFER_BYTES;
        localparam int FILL_BITS = $clog2(BUF_BYTES + 1);
        localparam int BYTE_BITS = `CSI_LANE_BITS;

        // RAW10 packs four pixels in five bytes, RAW12 two pixels in three bytes
        localparam int RAW10_UNIT_BYTES  = 5;
        localparam int RAW10_UNIT_PIXELS = 4;
        localparam int RAW10_LSB_BITS    = 2;
        localparam int RAW12_UNIT_BYTES  = 3;
        localparam int RAW12_UNIT_PIXELS = 2;
        localparam int RAW12_LSB_BITS    = 4;

        logic [BYTE_BITS-1:0]   byte_q [BUF_BYTES];     // byte 0 is the oldest
        logic [BYTE_BITS-1:0]   byte_d [BUF_BYTES];
        logic [FILL_BITS-1:0]   fill_q;
        logic [FILL_BITS-1:0]   fill_d;
        logic [FILL_BITS-1:0]   group_bytes;
        logic [FILL_BITS-1:0]   drop_bytes;
        logic [FILL_BITS-1:0]   keep_bytes;
        logic                   supported;
        logic                   append;
        logic                   flush;
        logic [PIXEL_WIDTH-1:0] raw10_slot [`CSI_PIXELS_PER_BEAT];
        logic [PIXEL_WIDTH-1:0] raw12_slot [`CSI_PIXELS_PER_BEAT];

        always_comb
        begin
                case (line_format_i)
                FMT_RAW10: group_bytes = FILL_BITS'(`CSI_GROUP_BYTES_RAW10);
                FMT_RAW12: group_bytes = FILL_BITS'(`CSI_GROUP_BYTES_RAW12);
                default:   group_bytes = '0;
                endcase
        end

        assign supported     = (line_format_i != FMT_NONE);
        assign group_ready_o = supported && (fill_q >= group_bytes);

        // the first word lands before its format is registered, so it is always taken
        assign append = data_valid_i && (supported || !line_active_i);
        // leftovers go once the line ends, and an unsupported line keeps nothing
        assign flush  = !data_valid_i || (line_active_i && !supported);

        assign drop_bytes = group_ready_o ? group_bytes : '0;
        assign keep_bytes = fill_q - drop_bytes;

        always_comb
        begin
                for (int i = 0; i < BUF_BYTES; i++)
                begin
                        if (i + int'(drop_bytes) < BUF_BYTES)
                        begin
                                byte_d[i] = byte_q[i + int'(drop_bytes)];       // oldest group leaves
                        end
                        else
                        begin
                                byte_d[i] = '0;
                        end
                end
                for (int k = 0; k < `CSI_LANES; k++)
                begin
                        if (append && (int'(keep_bytes) + k < BUF_BYTES))
                        begin
                                byte_d[int'(keep_bytes) + k] = data_i[k*BYTE_BITS +: BYTE_BITS];
                        end
                end
                if (flush)
                begin
                        fill_d = '0;
                end
                else if (append)
                begin
                        fill_d = keep_bytes + FILL_BITS'(`CSI_LANES);
                end
                else
                begin
                        fill_d = keep_bytes;
                end
        end

        always_ff @(posedge clk_i)
        begin
                if (reset_i)
                begin
                        fill_q <= '0;
                end
                else
                begin
                        fill_q <= fill_d;
                end
        end

        always_ff @(posedge clk_i)
        begin
                byte_q <= byte_d;
        end

        // msbs come first in each unit, the packed lsb byte closes it
        always_comb
        begin
                for (int p = 0; p < `CSI_PIXELS_PER_BEAT; p++)
                begin
                        raw10_slot[p] = '0;
                        raw10_slot[p][PIXEL_WIDTH-1 -: BYTE_BITS] =
                                byte_q[RAW10_UNIT_BYTES*(p/RAW10_UNIT_PIXELS) + p%RAW10_UNIT_PIXELS];
                        raw10_slot[p][PIXEL_WIDTH-BYTE_BITS-1 -: RAW10_LSB_BITS] =
                                byte_q[RAW10_UNIT_BYTES*(p/RAW10_UNIT_PIXELS) + RAW10_UNIT_PIXELS]
                                        [RAW10_LSB_BITS*(p%RAW10_UNIT_PIXELS) +: RAW10_LSB_BITS];

                        raw12_slot[p] = '0;
                        raw12_slot[p][PIXEL_WIDTH-1 -: BYTE_BITS] =
                                byte_q[RAW12_UNIT_BYTES*(p/RAW12_UNIT_PIXELS) + p%RAW12_UNIT_PIXELS];
                        raw12_slot[p][PIXEL_WIDTH-BYTE_BITS-1 -: RAW12_LSB_BITS] =
                                byte_q[RAW12_UNIT_BYTES*(p/RAW12_UNIT_PIXELS) + RAW12_UNIT_PIXELS]
                                        [RAW12_LSB_BITS*(p%RAW12_UNIT_PIXELS) +: RAW12_LSB_BITS];

                        group_pixels_o[p*PIXEL_WIDTH +: PIXEL_WIDTH] =
                                (line_format_i == FMT_RAW12) ? raw12_slot[p] : raw10_slot[p];
                end
        end

endmodule

`default_nettype wire

/* src/raw_format_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module raw_format_decode (
        input  logic                          clk_i,
        input  logic                          reset_i,
        input  logic                          data_valid_i,
        input  csi_raw_pkg::csi_packet_type_e packet_type_i,
        output csi_raw_pkg::raw_format_e      line_format_o,
        output logic                          line_active_o
);
        import csi_raw_pkg::*;

        logic        line_active_q;
        logic        line_start;
        raw_format_e type_format;
        raw_format_e line_format_q;

        // first word of a line is the rising edge of the valid level
        assign line_start = data_valid_i && !line_active_q;

        always_comb
        begin
                case (packet_type_i)
                PKT_RAW10: type_format = FMT_RAW10;
                PKT_RAW12: type_format = FMT_RAW12;
                default:   type_format = FMT_NONE;      // raw14 and anything else yields no pixels
                endcase
        end

        always_ff @(posedge clk_i)
        begin
                if (reset_i)
                begin
                        line_active_q <= 1'b0;
                        line_format_q <= FMT_NONE;
                end
                else
                begin
                        line_active_q <= data_valid_i;  // stays high one cycle past the last word
                        if (line_start)
                        begin
                                line_format_q <= type_format;   // held until the next line starts
                        end
                end
        end

        assign line_active_o = line_active_q;
        assign line_format_o = line_format_q;

endmodule

`default_nettype wire

/* src/csi_raw_pkg.sv */
`default_nettype none

package csi_raw_pkg;

        // low three bits of the CSI-2 data type field
        typedef enum logic [2:0] {
                PKT_RAW10 = 3'd3,               // data type 0x2b
                PKT_RAW12 = 3'd4,               // data type 0x2c
                PKT_RAW14 = 3'd5                // data type 0x2d, not decoded here
        } csi_packet_type_e;

        // pixel format latched for the current line
        typedef enum logic [1:0] {
                FMT_NONE  = 2'd0,               // no line or an unsupported type
                FMT_RAW10 = 2'd1,
                FMT_RAW12 = 2'd2
        } raw_format_e;

endpackage

`default_nettype wire

/* src/csi_raw_consts.svh */
`ifndef CSI_RAW_CONSTS_SVH
`define CSI_RAW_CONSTS_SVH

// byte lanes on the receive side, one byte per lane per clock
`define CSI_LANES 4
`define CSI_LANE_BITS 8

// one input word carries a byte from every lane, lane 0 lowest
`define CSI_WORD_BITS (`CSI_LANES * `CSI_LANE_BITS)

`define CSI_PIXELS_PER_BEAT 8                   // pixels in every output beat

// bytes needed for one full beat of eight pixels
`define CSI_GROUP_BYTES_RAW10 10                // two units of five bytes
`define CSI_GROUP_BYTES_RAW12 12                // four units of three bytes

// holds up to a group minus one byte plus a freshly arrived word
`define CSI_BUFFER_BYTES 16

`endif
